//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -sv -f filelist.f --top-module dtpu_tb -Mdir obj_dir
	./obj_dir/Vdtpu_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "TEST FAILED, run ended early"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
+incdir+hdl
hdl/dtpu_pkg.sv
hdl/dtpu_mxu_if.sv
hdl/dtpu_mxu.sv
hdl/dtpu_control_unit.sv
hdl/dtpu_core.sv
testbench/dtpu_tb_mem.sv
testbench/dtpu_tb.sv

//--- hdl/dtpu_control_unit.sv
`timescale 1ns/1ns
`include "dtpu_defines.svh"

module dtpu_control_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    // CSR block RAM
    output logic [`DTPU_CSR_AW-1:0]     csr_address,
    output logic                        csr_ce,
    output logic                        csr_we,
    output logic [7:0]                  csr_din,
    input  logic [7:0]                  csr_dout,
    // Weight block RAM
    output logic [`DTPU_WM_AW-1:0]      wm_address,
    output logic                        wm_ce,
    input  logic [`DTPU_WORD_WIDTH-1:0] wm_dout,
    // First word fall through input FIFO
    input  logic [`DTPU_WORD_WIDTH-1:0] infifo_dout,
    input  logic                        infifo_is_empty,
    output logic                        infifo_read,
    // Output FIFO
    output logic [`DTPU_WORD_WIDTH-1:0] outfifo_din,
    output logic                        outfifo_write,
    input  logic                        outfifo_is_full,
    // Host control
    input  logic                        cs_start,
    output logic                        cs_ready,
    output logic                        cs_done,
    input  logic                        cs_continue,
    output logic                        cs_idle,
    // Array
    dtpu_mxu_if.ctrl                    mxu
);

    localparam logic [`DTPU_CSR_AW-1:0] ADDR_COUNT  = `DTPU_CSR_COUNT;
    localparam logic [`DTPU_CSR_AW-1:0] ADDR_STATUS = `DTPU_CSR_STATUS;
    localparam logic [`DTPU_CSR_AW-1:0] ADDR_TILE   = `DTPU_CSR_TILE;
    localparam int PAD_W = `DTPU_WORD_WIDTH - $bits(dtpu_pkg::out_vec_t);

    dtpu_pkg::cu_state_t state_q;
    logic [1:0]          phase_q;

    // Job parameters and progress
    logic [7:0]          count_q;
    logic [7:0]          tile_q;
    logic [7:0]          issued_q;
    logic [7:0]          written_q;

    //////////////////////////////////////////////////
    // Datapath and flow control
    //////////////////////////////////////////////////

    // Stall on host enable or a full output FIFO
    assign mxu.advance = enable && !outfifo_is_full;

    assign mxu.in_vec  = infifo_dout[$bits(dtpu_pkg::in_vec_t)-1:0];
    assign mxu.tile    = wm_dout[$bits(dtpu_pkg::weight_tile_t)-1:0];
    assign outfifo_din = {{PAD_W{1'b0}}, mxu.out_vec};

    // Pull a vector only while some remain
    assign infifo_read = (state_q == dtpu_pkg::CU_STREAM) && (issued_q != count_q)
                         && !infifo_is_empty && mxu.advance;
    assign mxu.in_valid = infifo_read;

    assign outfifo_write = ((state_q == dtpu_pkg::CU_STREAM) ||
                            (state_q == dtpu_pkg::CU_DRAIN)) && mxu.out_valid && mxu.advance;

    // Weight word arrives one cycle after the fetch
    assign mxu.load_w = (state_q == dtpu_pkg::CU_FETCH_W) && (phase_q == 2'd1);

    // Host handshake
    assign cs_idle  = (state_q == dtpu_pkg::CU_IDLE);
    assign cs_ready = cs_idle && cs_start;
    assign cs_done  = (state_q == dtpu_pkg::CU_DONE);

    // Memory strobes
    always_comb begin
        csr_ce      = 1'b0;
        csr_we      = 1'b0;
        csr_address = ADDR_COUNT;
        csr_din     = written_q;
        wm_ce       = 1'b0;
        wm_address  = {{(`DTPU_WM_AW-8){1'b0}}, tile_q};
        case (state_q)
            dtpu_pkg::CU_READ_CSR: begin
                // Count byte then tile byte
                csr_ce      = (phase_q != 2'd2);
                csr_address = (phase_q == 2'd0) ? ADDR_COUNT : ADDR_TILE;
            end
            dtpu_pkg::CU_FETCH_W: begin
                wm_ce = (phase_q == 2'd0);
            end
            dtpu_pkg::CU_WRITE_STATUS: begin
                csr_ce      = 1'b1;
                csr_we      = 1'b1;
                csr_address = ADDR_STATUS;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Job sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= dtpu_pkg::CU_IDLE;
            phase_q   <= 2'd0;
            count_q   <= 8'd0;
            tile_q    <= 8'd0;
            issued_q  <= 8'd0;
            written_q <= 8'd0;
        end else begin
            if (outfifo_write) begin
                written_q <= written_q + 8'd1;
            end
            if (infifo_read) begin
                issued_q <= issued_q + 8'd1;
            end
            case (state_q)
                dtpu_pkg::CU_IDLE: begin
                    if (cs_start) begin
                        issued_q  <= 8'd0;
                        written_q <= 8'd0;
                        phase_q   <= 2'd0;
                        state_q   <= dtpu_pkg::CU_READ_CSR;
                    end
                end
                dtpu_pkg::CU_READ_CSR: begin
                    phase_q <= phase_q + 2'd1;
                    if (phase_q == 2'd1) begin
                        count_q <= csr_dout;
                    end
                    if (phase_q == 2'd2) begin
                        tile_q  <= csr_dout;
                        phase_q <= 2'd0;
                        // Empty job goes straight to status
                        state_q <= (count_q == 8'd0) ? dtpu_pkg::CU_WRITE_STATUS
                                                     : dtpu_pkg::CU_FETCH_W;
                    end
                end
                dtpu_pkg::CU_FETCH_W: begin
                    phase_q <= phase_q + 2'd1;
                    if (phase_q == 2'd1) begin
                        phase_q <= 2'd0;
                        state_q <= dtpu_pkg::CU_STREAM;
                    end
                end
                dtpu_pkg::CU_STREAM: begin
                    // Last vector issued
                    if (infifo_read && (issued_q + 8'd1 == count_q)) begin
                        state_q <= dtpu_pkg::CU_DRAIN;
                    end
                end
                dtpu_pkg::CU_DRAIN: begin
                    if (outfifo_write && (written_q + 8'd1 == count_q)) begin
                        state_q <= dtpu_pkg::CU_WRITE_STATUS;
                    end
                end
                dtpu_pkg::CU_WRITE_STATUS: begin
                    state_q <= dtpu_pkg::CU_DONE;
                end
                dtpu_pkg::CU_DONE: begin
                    if (cs_continue) begin
                        state_q <= dtpu_pkg::CU_IDLE;
                    end
                end
                default: begin
                    state_q <= dtpu_pkg::CU_IDLE;
                end
            endcase
        end
    end

    // At most two vectors in the array pipeline
    a_two_in_flight : assert property (
        @(posedge clk) disable iff (rst)
        (issued_q - written_q) <= 8'd2
    );

    // No result past the job count reaches the output FIFO
    a_no_extra_write : assert property (
        @(posedge clk) disable iff (rst)
        outfifo_write |-> (written_q != count_q)
    );

endmodule

//--- hdl/dtpu_core.sv
`timescale 1ns/1ns
`include "dtpu_defines.svh"

module dtpu_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    // CSR block RAM
    output logic [`DTPU_CSR_AW-1:0]     csr_address,
    output logic                        csr_ce,
    output logic                        csr_we,
    output logic [7:0]                  csr_din,
    input  logic [7:0]                  csr_dout,
    // Weight block RAM
    output logic [`DTPU_WM_AW-1:0]      wm_address,
    output logic                        wm_ce,
    input  logic [`DTPU_WORD_WIDTH-1:0] wm_dout,
    // Input FIFO
    input  logic [`DTPU_WORD_WIDTH-1:0] infifo_dout,
    input  logic                        infifo_is_empty,
    output logic                        infifo_read,
    // Output FIFO
    output logic [`DTPU_WORD_WIDTH-1:0] outfifo_din,
    output logic                        outfifo_write,
    input  logic                        outfifo_is_full,
    // Host control
    input  logic                        cs_start,
    output logic                        cs_ready,
    output logic                        cs_done,
    input  logic                        cs_continue,
    output logic                        cs_idle
);

    // Control unit to array link
    dtpu_mxu_if mxu_bus ();

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////
    dtpu_control_unit u_cu (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .csr_address     (csr_address),
        .csr_ce          (csr_ce),
        .csr_we          (csr_we),
        .csr_din         (csr_din),
        .csr_dout        (csr_dout),
        .wm_address      (wm_address),
        .wm_ce           (wm_ce),
        .wm_dout         (wm_dout),
        .infifo_dout     (infifo_dout),
        .infifo_is_empty (infifo_is_empty),
        .infifo_read     (infifo_read),
        .outfifo_din     (outfifo_din),
        .outfifo_write   (outfifo_write),
        .outfifo_is_full (outfifo_is_full),
        .cs_start        (cs_start),
        .cs_ready        (cs_ready),
        .cs_done         (cs_done),
        .cs_continue     (cs_continue),
        .cs_idle         (cs_idle),
        .mxu             (mxu_bus.ctrl)
    );

    //////////////////////////////////////////////////
    // MAC array
    //////////////////////////////////////////////////
    dtpu_mxu u_mxu (
        .clk (clk),
        .rst (rst),
        .mxu (mxu_bus.array)
    );

endmodule

//--- hdl/dtpu_defines.svh
`ifndef DTPU_DEFINES_SVH
`define DTPU_DEFINES_SVH

// Array geometry
`define DTPU_ROWS        3
`define DTPU_COLS        3

// Signed element and accumulator lane widths
`define DTPU_ELEM_WIDTH  4
`define DTPU_ACC_WIDTH   16

// FIFO and weight memory word
`define DTPU_WORD_WIDTH  64

// Block RAM address widths, 1024 CSR bytes and 8192 weight words
`define DTPU_CSR_AW      10
`define DTPU_WM_AW       13

// CSR byte map
`define DTPU_CSR_COUNT   0
`define DTPU_CSR_STATUS  1
`define DTPU_CSR_TILE    2

`endif

//--- hdl/dtpu_mxu.sv
`timescale 1ns/1ns
`include "dtpu_defines.svh"

module dtpu_mxu (
    input  logic       clk,
    input  logic       rst,
    dtpu_mxu_if.array  mxu
);

    localparam int ROWS      = `DTPU_ROWS;
    localparam int COLS      = `DTPU_COLS;
    localparam int PROD_W    = 2 * `DTPU_ELEM_WIDTH;

    // Stationary weights
    dtpu_pkg::weight_tile_t w_q;

    // Stage 1, one product per cell
    logic                     s1_valid;
    logic signed [PROD_W-1:0] prod_q [ROWS][COLS];

    // Row sums feeding stage 2
    dtpu_pkg::out_vec_t row_sum;

    //////////////////////////////////////////////////
    // Weight register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (mxu.load_w) begin
            w_q <= mxu.tile;
        end
    end

    //////////////////////////////////////////////////
    // Valid pipeline
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid      <= 1'b0;
            mxu.out_valid <= 1'b0;
        end else if (mxu.advance) begin
            s1_valid      <= mxu.in_valid;
            mxu.out_valid <= s1_valid;
        end
    end

    // Row reduction over stage 1 products
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < COLS; c++) begin
                // Sign extend each 8 bit product into the lane
                row_sum[r] = $signed(row_sum[r]) + $signed(prod_q[r][c]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Data pipeline
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (mxu.advance) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    // W[r][c] times x[c]
                    prod_q[r][c] <= $signed(w_q[r*COLS+c]) * $signed(mxu.in_vec[c]);
                end
            end
            mxu.out_vec <= row_sum;
        end
    end

    // Valid flag must be clean once out of reset
    a_out_valid_known : assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(mxu.out_valid)
    );

endmodule

//--- hdl/dtpu_mxu_if.sv
`timescale 1ns/1ns

interface dtpu_mxu_if;

    // Weight load
    logic                   load_w;
    dtpu_pkg::weight_tile_t tile;

    // Pipeline step enable, low holds every stage
    logic                   advance;

    // Input vector into stage 1
    logic                   in_valid;
    dtpu_pkg::in_vec_t      in_vec;

    // Result out of stage 2
    logic                   out_valid;
    dtpu_pkg::out_vec_t     out_vec;

    // Control unit side
    modport ctrl (
        output load_w, tile, advance, in_valid, in_vec,
        input  out_valid, out_vec
    );

    // Array side
    modport array (
        input  load_w, tile, advance, in_valid, in_vec,
        output out_valid, out_vec
    );

endinterface

//--- hdl/dtpu_pkg.sv
`include "dtpu_defines.svh"

package dtpu_pkg;

    //////////////////////////////////////////////////
    // Controller states
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        CU_IDLE,
        CU_READ_CSR,
        CU_FETCH_W,
        CU_STREAM,
        CU_DRAIN,
        CU_WRITE_STATUS,
        CU_DONE
    } cu_state_t;

    //////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////
    typedef logic signed [`DTPU_ELEM_WIDTH-1:0] elem_t;
    typedef logic signed [`DTPU_ACC_WIDTH-1:0]  acc_t;

    // Lane 3r+c holds W[r][c]
    typedef elem_t [`DTPU_ROWS*`DTPU_COLS-1:0] weight_tile_t;

    // Lane c holds x[c]
    typedef elem_t [`DTPU_COLS-1:0] in_vec_t;

    // Lane r holds y[r]
    typedef acc_t [`DTPU_ROWS-1:0] out_vec_t;

endpackage

//--- testbench/dtpu_tb.sv
`timescale 1ns/1ns
`include "dtpu_defines.svh"

module dtpu_tb;

    logic                        clk;
    logic                        rst;
    logic                        enable;
    logic [`DTPU_CSR_AW-1:0]     csr_address;
    logic                        csr_ce;
    logic                        csr_we;
    logic [7:0]                  csr_din;
    logic [7:0]                  csr_dout;
    logic [`DTPU_WM_AW-1:0]      wm_address;
    logic                        wm_ce;
    logic [`DTPU_WORD_WIDTH-1:0] wm_dout;
    logic [`DTPU_WORD_WIDTH-1:0] infifo_dout;
    logic                        infifo_is_empty;
    logic                        infifo_read;
    logic [`DTPU_WORD_WIDTH-1:0] outfifo_din;
    logic                        outfifo_write;
    logic                        outfifo_is_full;
    logic                        cs_start;
    logic                        cs_ready;
    logic                        cs_done;
    logic                        cs_continue;
    logic                        cs_idle;

    // Memory model setup port
    logic                        load_en;
    logic [1:0]                  load_sel;
    logic [`DTPU_WM_AW-1:0]      load_addr;
    logic [`DTPU_WORD_WIDTH-1:0] load_data;
    logic                        in_gap;

    int seed = 36;

    // Weight words 0 to 3 as loaded
    logic [`DTPU_WORD_WIDTH-1:0] wts [4];

    // Everything the core wrote to the output FIFO
    logic [`DTPU_WORD_WIDTH-1:0] got_q [$];
    int                          n_reads = 0;

    // Vectors already in the input FIFO for a later job
    logic [`DTPU_WORD_WIDTH-1:0] parked_q [$];

    dtpu_core u_dtpu_core (.*);

    dtpu_tb_mem u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Compare, model and helpers
    //////////////////////////////////////////////////
    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // Lane r holds the sum over c of W[r][c] * x[c] in 16 bits
    // Bits 63:48 stay zero
    function automatic logic [63:0] mac_ref(input logic [63:0] w, input logic [63:0] x);
        logic [63:0] y;
        int          acc;
        y = '0;
        for (int r = 0; r < 3; r++) begin
            acc = 0;
            for (int c = 0; c < 3; c++) begin
                acc += int'($signed(w[4*(3*r+c) +: 4])) * int'($signed(x[4*c +: 4]));
            end
            y[16*r +: 16] = acc[15:0];
        end
        return y;
    endfunction

    task automatic load_word(input logic [1:0] sel, input logic [12:0] addr,
                             input logic [63:0] data);
        @(negedge clk);
        load_en   = 1'b1;
        load_sel  = sel;
        load_addr = addr;
        load_data = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // FIFO strobes sampled on the active edge
    always @(posedge clk) begin
        if (outfifo_write) begin
            check_val("outfifo_is_full at write", 64'(outfifo_is_full), 64'd0);
            got_q.push_back(outfifo_din);
        end
        if (infifo_read) begin
            check_val("infifo_is_empty at read", 64'(infifo_is_empty), 64'd0);
            n_reads++;
        end
    end

    //////////////////////////////////////////////////
    // Job runner
    //////////////////////////////////////////////////
    // Mode 0 runs clean
    // Mode 1 adds output FIFO full stretches
    // Mode 2 adds input gaps and a stretch of enable low
    task automatic run_job(input int count, input logic [1:0] tile, input int mode);
        logic [63:0] exp_q [$];
        logic [63:0] x;
        int          base;
        int          reads0;
        int          cycles;
        load_word(2'd0, 13'(`DTPU_CSR_COUNT), 64'(count));
        load_word(2'd0, 13'(`DTPU_CSR_TILE), 64'(tile));
        for (int i = 0; i < count; i++) begin
            // Parked vectors come out of the FIFO first
            if (parked_q.size() > 0) begin
                x = parked_q.pop_front();
            end else begin
                x = {$random(seed), $random(seed)};
                load_word(2'd2, 13'd0, x);
            end
            exp_q.push_back(mac_ref(wts[tile], x));
        end
        base   = got_q.size();
        reads0 = n_reads;
        // Ready answers start in the same cycle
        @(negedge clk);
        cs_start = 1'b1;
        @(posedge clk);
        check_val("cs_ready", 64'(cs_ready), 64'd1);
        @(negedge clk);
        cs_start = 1'b0;
        cycles   = 0;
        while (!cs_done) begin
            @(negedge clk);
            cycles++;
            if (cycles > 600) begin
                $display("Timeout: job with count %0d never raised cs_done", count);
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
            if (mode == 1 && ($random(seed) & 3) == 0) begin
                outfifo_is_full = !outfifo_is_full;
            end
            if (mode == 2) begin
                in_gap = (($random(seed) & 3) == 0);
                enable = !(cycles >= 10 && cycles < 18);
            end
        end
        outfifo_is_full = 1'b0;
        in_gap          = 1'b0;
        enable          = 1'b1;
        // Done holds until continue
        repeat (3) begin
            @(negedge clk);
            check_val("cs_done", 64'(cs_done), 64'd1);
        end
        check_val("output word count", 64'(got_q.size() - base), 64'(count));
        for (int i = 0; i < count; i++) begin
            check_val("outfifo_din", got_q[base+i], exp_q[i]);
        end
        check_val("infifo_read count", 64'(n_reads - reads0), 64'(count));
        check_val("csr status byte", 64'(u_mem.csr_mem[`DTPU_CSR_STATUS]), 64'(count));
        cs_continue = 1'b1;
        @(negedge clk);
        cs_continue = 1'b0;
        check_val("cs_idle", 64'(cs_idle), 64'd1);
        check_val("cs_done", 64'(cs_done), 64'd0);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic check_reset_state();
        check_val("cs_idle", 64'(cs_idle), 64'd1);
        check_val("cs_ready", 64'(cs_ready), 64'd0);
        check_val("cs_done", 64'(cs_done), 64'd0);
        check_val("infifo_read", 64'(infifo_read), 64'd0);
        check_val("outfifo_write", 64'(outfifo_write), 64'd0);
        check_val("csr_ce", 64'(csr_ce), 64'd0);
        check_val("csr_we", 64'(csr_we), 64'd0);
        check_val("wm_ce", 64'(wm_ce), 64'd0);
    endtask

    task automatic load_weights();
        for (int i = 0; i < 4; i++) begin
            wts[i] = {$random(seed), $random(seed)};
            load_word(2'd1, 13'(i), wts[i]);
        end
    endtask

    task automatic job_basic();
        run_job(5, 2'd0, 0);
    endtask

    task automatic job_backpressure();
        run_job(8, 2'd0, 1);
    endtask

    task automatic job_gaps_enable();
        run_job(6, 2'd0, 2);
    endtask

    // Empty job with a waiting vector it must leave alone
    task automatic job_empty();
        logic [63:0] x;
        x = {$random(seed), $random(seed)};
        load_word(2'd2, 13'd0, x);
        parked_q.push_back(x);
        run_job(0, 2'd0, 0);
    endtask

    // First vector is the one the empty job left
    task automatic job_tile3();
        run_job(4, 2'd3, 0);
    endtask

    initial begin
        rst             = 1'b1;
        enable          = 1'b1;
        cs_start        = 1'b0;
        cs_continue     = 1'b0;
        outfifo_is_full = 1'b0;
        load_en         = 1'b0;
        load_sel        = 2'd0;
        load_addr       = '0;
        load_data       = '0;
        in_gap          = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        load_weights();
        job_basic();
        job_backpressure();
        job_gaps_enable();
        job_empty();
        job_tile3();
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- testbench/dtpu_tb_mem.sv
`timescale 1ns/1ns
`include "dtpu_defines.svh"

module dtpu_tb_mem (
    input  logic                        clk,
    // Setup writes, sel 0 CSR, 1 weight RAM, 2 input FIFO push
    input  logic                        load_en,
    input  logic [1:0]                  load_sel,
    input  logic [`DTPU_WM_AW-1:0]      load_addr,
    input  logic [`DTPU_WORD_WIDTH-1:0] load_data,
    input  logic                        in_gap,
    // CSR block RAM
    input  logic [`DTPU_CSR_AW-1:0]     csr_address,
    input  logic                        csr_ce,
    input  logic                        csr_we,
    input  logic [7:0]                  csr_din,
    output logic [7:0]                  csr_dout,
    // Weight block RAM
    input  logic [`DTPU_WM_AW-1:0]      wm_address,
    input  logic                        wm_ce,
    output logic [`DTPU_WORD_WIDTH-1:0] wm_dout,
    // Input FIFO, first word fall through
    output logic [`DTPU_WORD_WIDTH-1:0] infifo_dout,
    output logic                        infifo_is_empty,
    input  logic                        infifo_read
);

    logic [7:0]                  csr_mem [1024];
    logic [`DTPU_WORD_WIDTH-1:0] wm_mem [8192];
    logic [`DTPU_WORD_WIDTH-1:0] in_mem [64];

    // Read registers, one cycle latency
    logic [7:0]                  csr_rd = '0;
    logic [`DTPU_WORD_WIDTH-1:0] wm_rd = '0;

    // FIFO pointers, wrap at 64 words
    logic [5:0] in_wr = '0;
    logic [5:0] in_rd = '0;

    assign csr_dout = csr_rd;
    assign wm_dout  = wm_rd;

    // Gap input fakes an empty FIFO
    assign infifo_is_empty = (in_rd == in_wr) || in_gap;
    assign infifo_dout     = (in_rd == in_wr) ? '0 : in_mem[in_rd];

    //////////////////////////////////////////////////
    // Memories and FIFO storage
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (load_en) begin
            case (load_sel)
                2'd0: csr_mem[load_addr[`DTPU_CSR_AW-1:0]] <= load_data[7:0];
                2'd1: wm_mem[load_addr] <= load_data;
                2'd2: begin
                    in_mem[in_wr] <= load_data;
                    in_wr         <= in_wr + 6'd1;
                end
                default: ;
            endcase
        end
        // Read first, write lands after
        if (csr_ce) begin
            csr_rd <= csr_mem[csr_address];
            if (csr_we) begin
                csr_mem[csr_address] <= csr_din;
            end
        end
        if (wm_ce) begin
            wm_rd <= wm_mem[wm_address];
        end
        // Pop on read strobe
        if (infifo_read) begin
            in_rd <= in_rd + 6'd1;
        end
    end

endmodule
